// ==== hw/aes_pkg.sv ====
package aes_pkg;

        // byte 0 is the most significant byte, as in FIPS-197.
        typedef logic [0:15][7:0] block_t;
        typedef logic [0:15][7:0] key_t;

        typedef enum logic [2:0] {
                idle,
                key_wait,
                add_first,
                round,
                done
        } dec_state_e;

        ////////////////////////////////////////
        // inverse S-box.
        ////////////////////////////////////////

        localparam logic [7:0] inv_sbox_tab [0:255] = '{
                8'h52, 8'h09, 8'h6a, 8'hd5, 8'h30, 8'h36, 8'ha5, 8'h38,
                8'hbf, 8'h40, 8'ha3, 8'h9e, 8'h81, 8'hf3, 8'hd7, 8'hfb,
                8'h7c, 8'he3, 8'h39, 8'h82, 8'h9b, 8'h2f, 8'hff, 8'h87,
                8'h34, 8'h8e, 8'h43, 8'h44, 8'hc4, 8'hde, 8'he9, 8'hcb,
                8'h54, 8'h7b, 8'h94, 8'h32, 8'ha6, 8'hc2, 8'h23, 8'h3d,
                8'hee, 8'h4c, 8'h95, 8'h0b, 8'h42, 8'hfa, 8'hc3, 8'h4e,
                8'h08, 8'h2e, 8'ha1, 8'h66, 8'h28, 8'hd9, 8'h24, 8'hb2,
                8'h76, 8'h5b, 8'ha2, 8'h49, 8'h6d, 8'h8b, 8'hd1, 8'h25,
                8'h72, 8'hf8, 8'hf6, 8'h64, 8'h86, 8'h68, 8'h98, 8'h16,
                8'hd4, 8'ha4, 8'h5c, 8'hcc, 8'h5d, 8'h65, 8'hb6, 8'h92,
                8'h6c, 8'h70, 8'h48, 8'h50, 8'hfd, 8'hed, 8'hb9, 8'hda,
                8'h5e, 8'h15, 8'h46, 8'h57, 8'ha7, 8'h8d, 8'h9d, 8'h84,
                8'h90, 8'hd8, 8'hab, 8'h00, 8'h8c, 8'hbc, 8'hd3, 8'h0a,
                8'hf7, 8'he4, 8'h58, 8'h05, 8'hb8, 8'hb3, 8'h45, 8'h06,
                8'hd0, 8'h2c, 8'h1e, 8'h8f, 8'hca, 8'h3f, 8'h0f, 8'h02,
                8'hc1, 8'haf, 8'hbd, 8'h03, 8'h01, 8'h13, 8'h8a, 8'h6b,
                8'h3a, 8'h91, 8'h11, 8'h41, 8'h4f, 8'h67, 8'hdc, 8'hea,
                8'h97, 8'hf2, 8'hcf, 8'hce, 8'hf0, 8'hb4, 8'he6, 8'h73,
                8'h96, 8'hac, 8'h74, 8'h22, 8'he7, 8'had, 8'h35, 8'h85,
                8'he2, 8'hf9, 8'h37, 8'he8, 8'h1c, 8'h75, 8'hdf, 8'h6e,
                8'h47, 8'hf1, 8'h1a, 8'h71, 8'h1d, 8'h29, 8'hc5, 8'h89,
                8'h6f, 8'hb7, 8'h62, 8'h0e, 8'haa, 8'h18, 8'hbe, 8'h1b,
                8'hfc, 8'h56, 8'h3e, 8'h4b, 8'hc6, 8'hd2, 8'h79, 8'h20,
                8'h9a, 8'hdb, 8'hc0, 8'hfe, 8'h78, 8'hcd, 8'h5a, 8'hf4,
                8'h1f, 8'hdd, 8'ha8, 8'h33, 8'h88, 8'h07, 8'hc7, 8'h31,
                8'hb1, 8'h12, 8'h10, 8'h59, 8'h27, 8'h80, 8'hec, 8'h5f,
                8'h60, 8'h51, 8'h7f, 8'ha9, 8'h19, 8'hb5, 8'h4a, 8'h0d,
                8'h2d, 8'he5, 8'h7a, 8'h9f, 8'h93, 8'hc9, 8'h9c, 8'hef,
                8'ha0, 8'he0, 8'h3b, 8'h4d, 8'hae, 8'h2a, 8'hf5, 8'hb0,
                8'hc8, 8'heb, 8'hbb, 8'h3c, 8'h83, 8'h53, 8'h99, 8'h61,
                8'h17, 8'h2b, 8'h04, 8'h7e, 8'hba, 8'h77, 8'hd6, 8'h26,
                8'he1, 8'h69, 8'h14, 8'h63, 8'h55, 8'h21, 8'h0c, 8'h7d
        };

        function automatic block_t inv_sub_bytes(input block_t s);
                block_t r;
                for (int i = 0; i < 16; i++) begin
                        r[i] = inv_sbox_tab[s[i]];
                end
                return r;
        endfunction

        // state byte (row, col) sits at index row + 4 * col.
        // row r rotates right by r positions.
        function automatic block_t inv_shift_rows(input block_t s);
                block_t r;
                for (int c = 0; c < 4; c++) begin
                        for (int row = 0; row < 4; row++) begin
                                r[row + 4 * c] = s[row + 4 * ((c - row) & 3)];
                        end
                end
                return r;
        endfunction

        ////////////////////////////////////////
        // GF(2^8) arithmetic.
        ////////////////////////////////////////

        function automatic logic [7:0] xtime(input logic [7:0] b);
                return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
        endfunction

        // multiplies by a constant below 16, built from doublings.
        function automatic logic [7:0] gf_mul(input logic [7:0] b, input logic [3:0] k);
                logic [7:0] x2;
                logic [7:0] x4;
                logic [7:0] x8;
                x2 = xtime(b);
                x4 = xtime(x2);
                x8 = xtime(x4);
                return (k[3] ? x8 : 8'h00) ^ (k[2] ? x4 : 8'h00) ^
                       (k[1] ? x2 : 8'h00) ^ (k[0] ? b : 8'h00);
        endfunction

        function automatic block_t inv_mix_cols(input block_t s);
                block_t r;
                logic [7:0] a0;
                logic [7:0] a1;
                logic [7:0] a2;
                logic [7:0] a3;
                for (int c = 0; c < 4; c++) begin
                        a0 = s[4 * c];
                        a1 = s[4 * c + 1];
                        a2 = s[4 * c + 2];
                        a3 = s[4 * c + 3];
                        r[4 * c] = gf_mul(a0, 4'he) ^ gf_mul(a1, 4'hb) ^
                                   gf_mul(a2, 4'hd) ^ gf_mul(a3, 4'h9);
                        r[4 * c + 1] = gf_mul(a0, 4'h9) ^ gf_mul(a1, 4'he) ^
                                       gf_mul(a2, 4'hb) ^ gf_mul(a3, 4'hd);
                        r[4 * c + 2] = gf_mul(a0, 4'hd) ^ gf_mul(a1, 4'h9) ^
                                       gf_mul(a2, 4'he) ^ gf_mul(a3, 4'hb);
                        r[4 * c + 3] = gf_mul(a0, 4'hb) ^ gf_mul(a1, 4'hd) ^
                                       gf_mul(a2, 4'h9) ^ gf_mul(a3, 4'he);
                end
                return r;
        endfunction

endpackage

// ==== hw/dec_ctrl_if.sv ====
`timescale 1ns/100ps

interface dec_ctrl_if #(
        parameter int aw = 4
) ();

        logic load;
        logic start;
        logic step;
        logic add_key;
        logic do_round;
        logic last;
        logic [aw-1:0] key_addr;

        modport fsm (
                output load, start, step, add_key, do_round,
                input last
        );

        modport counter (
                input start, step,
                output last, key_addr
        );

        // last tells the datapath to skip InvMixColumns.
        modport datapath (
                input load, add_key, do_round, last
        );

        modport keymem (
                input key_addr
        );

endinterface

// ==== hw/aes_dec_fsm.sv ====
`timescale 1ns/100ps

module aes_dec_fsm import aes_pkg::*; (
        input  logic clk,
        input  logic reset,
        input  logic req,
        output logic ack,
        dec_ctrl_if.fsm ctrl
);

        dec_state_e state_q;
        dec_state_e state_d;

        always_ff @(posedge clk) begin
                if (reset) begin
                        state_q <= idle;
                end else begin
                        state_q <= state_d;
                end
        end

        always_comb begin
                state_d = state_q;
                ctrl.load = 1'b0;
                ctrl.start = 1'b0;
                ctrl.step = 1'b0;
                ctrl.add_key = 1'b0;
                ctrl.do_round = 1'b0;

                case (state_q)
                idle: begin
                        if (req) begin
                                ctrl.load = 1'b1;
                                ctrl.start = 1'b1;
                                state_d = key_wait;
                        end
                end
                // the key memory needs one cycle to return key[nr].
                key_wait: begin
                        state_d = add_first;
                end
                add_first: begin
                        ctrl.add_key = 1'b1;
                        ctrl.step = 1'b1;
                        state_d = round;
                end
                round: begin
                        ctrl.do_round = 1'b1;
                        ctrl.step = 1'b1;
                        if (ctrl.last) begin
                                state_d = done;
                        end
                end
                // plaintext is held here until the host drops req.
                done: begin
                        if (!req) begin
                                state_d = idle;
                        end
                end
                default: begin
                        state_d = idle;
                end
                endcase
        end

        assign ack = (state_q == done);

endmodule

// ==== hw/round_counter.sv ====
`timescale 1ns/100ps

module round_counter #(
        parameter int nr = 10
) (
        input logic clk,
        input logic reset,
        dec_ctrl_if.counter ctrl
);

        localparam int cw = $clog2(nr + 1);

        logic [cw-1:0] count;

        always_ff @(posedge clk) begin
                if (reset) begin
                        count <= '0;
                end else if (ctrl.start) begin
                        count <= cw'(nr);
                end else if (ctrl.step && !ctrl.last) begin
                        count <= count - cw'(1);
                end
        end

        assign ctrl.last = (count == '0);

        // the key memory has one cycle of read latency, so the address
        // runs one step ahead of the count while the count moves.
        assign ctrl.key_addr = (ctrl.step && !ctrl.last) ? count - cw'(1) : count;

endmodule

// ==== hw/round_key_ram.sv ====
`timescale 1ns/100ps

module round_key_ram import aes_pkg::*; #(
        parameter int nr = 10,
        localparam int aw = $clog2(nr + 1)
) (
        input  logic clk,
        input  logic we,
        input  logic [aw-1:0] waddr,
        input  key_t wdata,
        dec_ctrl_if.keymem ctrl,
        output key_t rkey
);

        key_t mem [0:nr];

        // writes past the last round key are dropped.
        always_ff @(posedge clk) begin
                if (we && int'(waddr) <= nr) begin
                        mem[waddr] <= wdata;
                end
        end

        always_ff @(posedge clk) begin
                rkey <= mem[ctrl.key_addr];
        end

endmodule

// ==== hw/inv_round.sv ====
`timescale 1ns/100ps

module inv_round import aes_pkg::*; (
        input  logic clk,
        input  logic reset,
        input  block_t ciphertext,
        input  key_t rkey,
        dec_ctrl_if.datapath ctrl,
        output block_t state
);

        block_t shifted;
        block_t subbed;
        block_t keyed;
        block_t round_out;

        // one inverse round in the FIPS-197 order.
        always_comb begin
                shifted = inv_shift_rows(state);
                subbed = inv_sub_bytes(shifted);
                keyed = subbed ^ rkey;
                round_out = ctrl.last ? keyed : inv_mix_cols(keyed);
        end

        always_ff @(posedge clk) begin
                if (reset) begin
                        state <= '0;
                end else if (ctrl.load) begin
                        state <= ciphertext;
                end else if (ctrl.add_key) begin
                        state <= state ^ rkey;
                end else if (ctrl.do_round) begin
                        state <= round_out;
                end
        end

endmodule

// ==== hw/aes_dec_top.sv ====
`timescale 1ns/100ps

module aes_dec_top import aes_pkg::*; #(
        parameter int nr = 10,
        localparam int aw = $clog2(nr + 1)
) (
        input  logic clk,
        input  logic reset,

        input  logic req,
        input  block_t ciphertext,
        output logic ack,
        output block_t plaintext,

        input  logic key_we,
        input  logic [aw-1:0] key_addr_w,
        input  key_t key_data
);

        key_t rkey;

        dec_ctrl_if #(.aw(aw)) ctrl ();

        ////////////////////////////////////////
        // control.
        ////////////////////////////////////////

        aes_dec_fsm fsm_i (
                .clk  (clk),
                .reset(reset),
                .req  (req),
                .ack  (ack),
                .ctrl (ctrl.fsm)
        );

        round_counter #(.nr(nr)) counter_i (
                .clk  (clk),
                .reset(reset),
                .ctrl (ctrl.counter)
        );

        ////////////////////////////////////////
        // data.
        ////////////////////////////////////////

        round_key_ram #(.nr(nr)) key_ram_i (
                .clk  (clk),
                .we   (key_we),
                .waddr(key_addr_w),
                .wdata(key_data),
                .ctrl (ctrl.keymem),
                .rkey (rkey)
        );

        // the state register doubles as the plaintext output.
        inv_round round_i (
                .clk       (clk),
                .reset     (reset),
                .ciphertext(ciphertext),
                .rkey      (rkey),
                .ctrl      (ctrl.datapath),
                .state     (plaintext)
        );

endmodule

// ==== tb/tb_aes_ref.svh ====
////////////////////////////////////////
// AES-128 key expansion.
////////////////////////////////////////

function automatic logic [7:0] gf_product(input logic [7:0] a, input logic [7:0] b);
        logic [7:0] p;
        logic [7:0] x;
        logic [7:0] y;
        p = 8'h00;
        x = a;
        y = b;
        for (int i = 0; i < 8; i++) begin
                if (y[0]) begin
                        p = p ^ x;
                end
                x = {x[6:0], 1'b0} ^ (x[7] ? 8'h1b : 8'h00);
                y = y >> 1;
        end
        return p;
endfunction

// the forward S-box, built from the field inverse and the affine map.
function automatic logic [7:0] forward_sbox(input logic [7:0] a);
        logic [7:0] inv;
        inv = 8'h00;
        for (int b = 1; b < 256; b++) begin
                if (gf_product(a, 8'(b)) == 8'h01) begin
                        inv = 8'(b);
                end
        end
        return inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]} ^
               {inv[4:0], inv[7:5]} ^ {inv[3:0], inv[7:4]} ^ 8'h63;
endfunction

// expands the cipher key and writes round keys 0 to 10, one per cycle.
task automatic load_round_keys(input logic [127:0] cipher_key);
        logic [31:0] w [0:43];
        logic [31:0] t;
        logic [7:0] rcon;
        rcon = 8'h01;
        for (int i = 0; i < 4; i++) begin
                w[i] = cipher_key[127 - 32 * i -: 32];
        end
        for (int i = 4; i < 44; i++) begin
                t = w[i - 1];
                if (i % 4 == 0) begin
                        t = {forward_sbox(t[23:16]), forward_sbox(t[15:8]),
                             forward_sbox(t[7:0]), forward_sbox(t[31:24])} ^ {rcon, 24'h0};
                        rcon = {rcon[6:0], 1'b0} ^ (rcon[7] ? 8'h1b : 8'h00);
                end
                w[i] = w[i - 4] ^ t;
        end
        for (int r = 0; r <= 10; r++) begin
                key_we = 1'b1;
                key_addr_w = aw'(r);
                key_data = {w[4 * r], w[4 * r + 1], w[4 * r + 2], w[4 * r + 3]};
                @(posedge clk);
                #2;
        end
        key_we = 1'b0;
endtask

////////////////////////////////////////
// four-phase request.
////////////////////////////////////////

task automatic idle_cycles(input int n);
        repeat (n) begin
                @(posedge clk);
                #2;
        end
endtask

task automatic wait_ack(input logic level, input string what);
        int cycles;
        cycles = 0;
        while (ack !== level && cycles < ack_timeout) begin
                @(posedge clk);
                #2;
                cycles++;
        end
        if (ack !== level) begin
                report_timeout(what);
        end
endtask

task automatic decrypt_block(input logic [127:0] ct, input int hold);
        ciphertext = ct;
        req = 1'b1;
        wait_ack(1'b1, "ack did not rise after req");
        idle_cycles(hold);
        req = 1'b0;
        wait_ack(1'b0, "ack did not fall after req dropped");
endtask

// ==== tb/tb_aes_dec.sv ====
`timescale 1ns/100ps

module tb_aes_dec;

        localparam int nr = 10;
        localparam int aw = $clog2(nr + 1);
        // ack rises this many edges after idle first samples req.
        localparam int latency = nr + 2;
        localparam int ack_timeout = 4 * latency;

        localparam logic [127:0] key_c1 = 128'h000102030405060708090a0b0c0d0e0f;
        localparam logic [127:0] ct_c1 = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
        localparam logic [127:0] pt_c1 = 128'h00112233445566778899aabbccddeeff;
        localparam logic [127:0] key_a1 = 128'h2b7e151628aed2a6abf7158809cf4f3c;
        localparam logic [127:0] ct_a1 = 128'h3925841d02dc09fbdc118597196a0b32;
        localparam logic [127:0] pt_a1 = 128'h3243f6a8885a308d313198a2e0370734;

        logic clk;
        logic reset;
        logic req;
        logic [127:0] ciphertext;
        logic ack;
        logic [127:0] plaintext;
        logic key_we;
        logic [aw-1:0] key_addr_w;
        logic [127:0] key_data;

        logic [127:0] expected_pt;
        logic prev_req;
        logic prev_ack;
        logic [127:0] prev_pt;
        int req_edges;

        int seed = 67521;
        int errors = 0;
        int errors_at_start = 0;
        int tests_run = 0;
        int tests_failed = 0;
        string test_name = "reset";

`include "tb_aes_ref.svh"

        initial begin
                clk = 1'b0;
                forever #10 clk = ~clk;
        end

        aes_dec_top #(.nr(nr)) aes_dec_top_i (
                .clk       (clk),
                .reset     (reset),
                .req       (req),
                .ciphertext(ciphertext),
                .ack       (ack),
                .plaintext (plaintext),
                .key_we    (key_we),
                .key_addr_w(key_addr_w),
                .key_data  (key_data)
        );

        ////////////////////////////////////////
        // checks.
        ////////////////////////////////////////

        // req_edges counts the edges that have seen req high in a row.
        always_ff @(posedge clk) begin
                if (reset) begin
                        prev_req <= 1'b0;
                        prev_ack <= 1'b0;
                        prev_pt <= '0;
                        req_edges <= 0;
                end else begin
                        prev_req <= req;
                        prev_ack <= ack;
                        prev_pt <= plaintext;
                        req_edges <= req ? req_edges + 1 : 0;
                end
        end

        ack_low_chk: assert property (@(posedge clk) disable iff (reset)
                (!req && !prev_req) |-> !ack)
                else begin
                        errors++;
                        $display("error %s: ack expected 0, actual %b", test_name, $sampled(ack));
                end

        // ack is first seen high one edge after it rises.
        latency_chk: assert property (@(posedge clk) disable iff (reset)
                (ack && !prev_ack) |-> (req_edges - 1 == latency))
                else begin
                        errors++;
                        $display("error %s: latency expected %0d, actual %0d",
                                 test_name, latency, $sampled(req_edges) - 1);
                end

        plaintext_chk: assert property (@(posedge clk) disable iff (reset)
                ack |-> (plaintext == expected_pt))
                else begin
                        errors++;
                        $display("error %s: plaintext expected %h, actual %h",
                                 test_name, expected_pt, $sampled(plaintext));
                end

        stable_chk: assert property (@(posedge clk) disable iff (reset)
                (ack && prev_ack) |-> (plaintext == prev_pt))
                else begin
                        errors++;
                        $display("error %s: held plaintext expected %h, actual %h",
                                 test_name, $sampled(prev_pt), $sampled(plaintext));
                end

        ack_hold_chk: assert property (@(posedge clk) disable iff (reset)
                (ack && req) |=> ack)
                else begin
                        errors++;
                        $display("error %s: held ack expected 1, actual %b", test_name, $sampled(ack));
                end

        ack_release_chk: assert property (@(posedge clk) disable iff (reset)
                (ack && !req) |=> !ack)
                else begin
                        errors++;
                        $display("error %s: released ack expected 0, actual %b",
                                 test_name, $sampled(ack));
                end

        ////////////////////////////////////////
        // bookkeeping.
        ////////////////////////////////////////

        task automatic begin_test(input string name);
                test_name = name;
                errors_at_start = errors;
        endtask

        task automatic end_test();
                tests_run++;
                if (errors == errors_at_start) begin
                        $display("test %s: ok", test_name);
                end else begin
                        tests_failed++;
                        $display("test %s: %0d errors", test_name, errors - errors_at_start);
                end
        endtask

        task automatic report_timeout(input string what);
                $display("timeout in test %s: %s", test_name, what);
                $display("FAIL: see errors above");
                $finish;
        endtask

        ////////////////////////////////////////
        // stimulus.
        ////////////////////////////////////////

        initial begin
                reset = 1'b1;
                req = 1'b0;
                ciphertext = '0;
                key_we = 1'b0;
                key_addr_w = '0;
                key_data = '0;
                expected_pt = '0;
                repeat (16) @(posedge clk);
                #2;
                reset = 1'b0;

                begin_test("reset");
                idle_cycles(4 + ($random(seed) & 7));
                end_test();

                begin_test("fips197_vector");
                load_round_keys(key_c1);
                expected_pt = pt_c1;
                decrypt_block(ct_c1, 0);
                end_test();

                // req stays high for a while after ack.
                begin_test("back_pressure");
                for (int n = 0; n < 3; n++) begin
                        idle_cycles($random(seed) & 3);
                        decrypt_block(ct_c1, 1 + ($random(seed) & 15));
                end
                end_test();

                begin_test("key_reload");
                load_round_keys(key_a1);
                expected_pt = pt_a1;
                decrypt_block(ct_a1, 0);
                end_test();

                begin_test("back_to_back");
                for (int v = 0; v < 2; v++) begin
                        load_round_keys(v == 0 ? key_c1 : key_a1);
                        expected_pt = (v == 0) ? pt_c1 : pt_a1;
                        for (int n = 0; n < 3; n++) begin
                                idle_cycles($random(seed) & 3);
                                decrypt_block(v == 0 ? ct_c1 : ct_a1, $random(seed) & 3);
                        end
                end
                end_test();

                idle_cycles(4);
                $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
                if (errors == 0) begin
                        $display("PASS: all tests");
                end else begin
                        $display("FAIL: see errors above");
                end
                $finish;
        end

endmodule

// ==== sources.f ====
+incdir+tb
hw/aes_pkg.sv
hw/dec_ctrl_if.sv
hw/aes_dec_fsm.sv
hw/round_counter.sv
hw/round_key_ram.sv
hw/inv_round.sv
hw/aes_dec_top.sv
tb/tb_aes_dec.sv

// ==== Makefile ====
# Verilator build for the AES decryption core.

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module aes_dec_top -f sources.f

sim:
	verilator --binary --timing --assert -j 0 --top-module tb_aes_dec \
		-f sources.f -o sim_tb
	./obj_dir/sim_tb | tee sim.log
	grep -q "PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log
